// ==== run_sim.sh ====
#!/bin/sh
# build and run the board supervisor testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_board_supervisor -f tb.f -o tb_board_supervisor \
    && ./obj_dir/tb_board_supervisor > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run did not complete"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && { echo "simulation reported a failure"; exit 1; } || exit 0

// ==== src/board_supervisor_top.sv ====
`include "supervisor_defs.svh"

module board_supervisor_top import supervisor_pkg::*; #(
    parameter int unsigned hold_time = `SUP_RESET_HOLD_TIME,
    parameter int unsigned slow_bit  = `SUP_SLOW_GLOW_BIT,
    parameter int unsigned fast_bit  = `SUP_FAST_GLOW_BIT,
    parameter int unsigned blink_bit = `SUP_BLINK_BIT
) (
    input  logic         control_clock,
    input  logic         reset_dc,
    input  logic         reset_opt,
    input  logic [1:0]   reset_conf,
    input  logic         pll54_locked,
    input  logic         pll_hdmi_locked,
    input  logic         resync,
    input  logic         force_generate,
    input  logic         adv7513_ready,
    output logic         dc_nreset,
    output logic         opt_nreset,
    output logic         status_led,
    output event_count_t pll54_lockloss_count,
    output event_count_t pll_hdmi_lockloss_count,
    output event_count_t resync_count
);

    supervisor_events_if events ();

    input_sync_stage sync_stage (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .pll54_locked(pll54_locked),
        .pll_hdmi_locked(pll_hdmi_locked),
        .resync(resync),
        .force_generate(force_generate),
        .adv7513_ready(adv7513_ready),
        .events(events.source)
    );

    event_count_stage count_stage (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .events(events.sink),
        .pll54_lockloss_count(pll54_lockloss_count),
        .pll_hdmi_lockloss_count(pll_hdmi_lockloss_count),
        .resync_count(resync_count)
    );

    ////////////////////////////////////////////////////////////////////////////
    // stretched resets
    ////////////////////////////////////////////////////////////////////////////
    reset_hold #(
        .hold_time(hold_time)
    ) dc_hold (
        .control_clock(control_clock),
        .request(reset_dc),
        .nreset(dc_nreset)
    );

    // console reset leaves the optional one alone
    reset_hold #(
        .hold_time(hold_time)
    ) opt_hold (
        .control_clock(control_clock),
        .request(reset_opt),
        .nreset(opt_nreset)
    );

    status_led_select #(
        .slow_bit(slow_bit),
        .fast_bit(fast_bit),
        .blink_bit(blink_bit)
    ) led_select (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .reset_conf(reset_conf_e'(reset_conf)),
        .events(events.sink),
        .dc_nreset(dc_nreset),
        .opt_nreset(opt_nreset),
        .status_led(status_led)
    );

endmodule

// ==== src/event_count_stage.sv ====
module event_count_stage import supervisor_pkg::*; (
    input  logic         control_clock,
    input  logic         reset_dc,
    supervisor_events_if.sink events,
    output event_count_t pll54_lockloss_count,
    output event_count_t pll_hdmi_lockloss_count,
    output event_count_t resync_count
);

    // one increment per event pulse
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            pll54_lockloss_count    <= '0;
            pll_hdmi_lockloss_count <= '0;
            resync_count            <= '0;
        end else begin
            if (events.pll54_lockloss) begin
                pll54_lockloss_count <= pll54_lockloss_count + 1'b1;
            end
            if (events.pll_hdmi_lockloss) begin
                pll_hdmi_lockloss_count <= pll_hdmi_lockloss_count + 1'b1;
            end
            if (events.resync_rise) begin
                resync_count <= resync_count + 1'b1;
            end
        end
    end

endmodule

// ==== src/input_sync_stage.sv ====
module input_sync_stage (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic pll54_locked,
    input  logic pll_hdmi_locked,
    input  logic resync,
    input  logic force_generate,
    input  logic adv7513_ready,
    supervisor_events_if.source events
);

    // bit positions in the synchronizer vectors
    localparam int pll54_lost_idx    = 0;
    localparam int pll_hdmi_lost_idx = 1;
    localparam int resync_idx        = 2;
    localparam int force_gen_idx     = 3;
    localparam int adv_ready_idx     = 4;

    logic [4:0] meta;
    logic [4:0] sync;
    logic       pll54_lost_prev;
    logic       pll_hdmi_lost_prev;
    logic       resync_prev;

    // locks enter inverted, so a loss is a rising edge
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            meta                     <= '0;
            sync                     <= '0;
            pll54_lost_prev          <= 1'b0;
            pll_hdmi_lost_prev       <= 1'b0;
            resync_prev              <= 1'b0;
            events.pll54_lockloss    <= 1'b0;
            events.pll_hdmi_lockloss <= 1'b0;
            events.resync_rise       <= 1'b0;
        end else begin
            meta <= {adv7513_ready, force_generate, resync, ~pll_hdmi_locked, ~pll54_locked};
            sync <= meta;
            pll54_lost_prev          <= sync[pll54_lost_idx];
            pll_hdmi_lost_prev       <= sync[pll_hdmi_lost_idx];
            resync_prev              <= sync[resync_idx];
            events.pll54_lockloss    <= sync[pll54_lost_idx] & ~pll54_lost_prev;
            events.pll_hdmi_lockloss <= sync[pll_hdmi_lost_idx] & ~pll_hdmi_lost_prev;
            events.resync_rise       <= sync[resync_idx] & ~resync_prev;
        end
    end

    assign events.pll_hdmi_ready        = ~sync[pll_hdmi_lost_idx];
    assign events.resync_active         = sync[resync_idx];
    assign events.force_generate_active = sync[force_gen_idx];
    assign events.adv_ready             = sync[adv_ready_idx];

endmodule

// ==== src/led_glow.sv ====
`include "supervisor_defs.svh"

module led_glow #(
    parameter int unsigned bit_pos = `SUP_SLOW_GLOW_BIT
) (
    input  logic control_clock,
    input  logic reset_dc,
    output logic glow
);

    // pwm resolution capped at 8 bits
    localparam int duty_w = (bit_pos / 2 > 8) ? 8 : ((bit_pos / 2 < 1) ? 1 : bit_pos / 2);

    logic [bit_pos:0]  count;
    logic [duty_w-1:0] ramp;
    logic [duty_w-1:0] duty;

    // top bit picks rising or falling half
    assign ramp = count[bit_pos-1 -: duty_w];
    assign duty = count[bit_pos] ? ~ramp : ramp;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            count <= '0;
            glow  <= 1'b0;
        end else begin
            count <= count + 1'b1;
            glow  <= duty > count[duty_w-1:0];
        end
    end

endmodule

// ==== src/reset_hold.sv ====
`include "supervisor_defs.svh"

module reset_hold #(
    parameter int unsigned hold_time = `SUP_RESET_HOLD_TIME
) (
    input  logic control_clock,
    input  logic request,
    output logic nreset
);

    localparam int cnt_w = (hold_time > 0) ? $clog2(hold_time + 1) : 1;

    // power-up state is released and idle
    logic [cnt_w-1:0] count   = cnt_w'(hold_time);
    logic             nreset_q = 1'b1;

    always_ff @(posedge control_clock) begin
        if (request) begin
            count    <= '0;
            nreset_q <= 1'b0;
        end else if (count == cnt_w'(hold_time)) begin
            nreset_q <= 1'b1;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign nreset = nreset_q;

endmodule

// ==== src/status_led_select.sv ====
`include "supervisor_defs.svh"

module status_led_select import supervisor_pkg::*; #(
    parameter int unsigned slow_bit  = `SUP_SLOW_GLOW_BIT,
    parameter int unsigned fast_bit  = `SUP_FAST_GLOW_BIT,
    parameter int unsigned blink_bit = `SUP_BLINK_BIT
) (
    input  logic        control_clock,
    input  logic        reset_dc,
    input  reset_conf_e reset_conf,
    supervisor_events_if.sink events,
    input  logic        dc_nreset,
    input  logic        opt_nreset,
    output logic        status_led
);

    logic               slow_level;
    logic               fast_level;
    logic [blink_bit:0] led_counter;
    logic               board_led;

    led_glow #(
        .bit_pos(slow_bit)
    ) slow_glow (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .glow(slow_level)
    );

    led_glow #(
        .bit_pos(fast_bit)
    ) fast_glow (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .glow(fast_level)
    );

    ////////////////////////////////////////////////////////////////////////////
    // board status with an active low led
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        if (!events.pll_hdmi_ready) begin
            board_led = 1'b1;
        end else if (events.resync_active) begin
            board_led = ~fast_level;
        end else if (events.force_generate_active) begin
            // blink the fast glow
            board_led = led_counter[blink_bit] ? ~fast_level : 1'b1;
        end else if (events.adv_ready) begin
            board_led = 1'b0;
        end else begin
            board_led = ~slow_level;
        end
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            led_counter <= '0;
            status_led  <= 1'b1;
        end else begin
            led_counter <= led_counter + 1'b1;
            case (reset_conf)
                led_board_status: status_led <= board_led;
                led_dc_reset:     status_led <= dc_nreset;
                default:          status_led <= opt_nreset;
            endcase
        end
    end

endmodule

// ==== src/supervisor_defs.svh ====
`ifndef SUPERVISOR_DEFS_SVH
`define SUPERVISOR_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// board supervisor defaults
////////////////////////////////////////////////////////////////////////////

// cycles a stretched reset stays low after its request ends
`define SUP_RESET_HOLD_TIME 32000000

// glow counter top bits set the breathing periods
`define SUP_SLOW_GLOW_BIT 26
`define SUP_FAST_GLOW_BIT 22

// led counter bit gating the blink in forced generation
`define SUP_BLINK_BIT 24

// event counter width
`define SUP_COUNT_WIDTH 32

`endif

// ==== src/supervisor_events_if.sv ====
interface supervisor_events_if;

    // synchronized levels
    logic pll_hdmi_ready;
    logic resync_active;
    logic force_generate_active;
    logic adv_ready;

    // single cycle event pulses
    logic pll54_lockloss;
    logic pll_hdmi_lockloss;
    logic resync_rise;

    modport source (
        output pll_hdmi_ready, resync_active, force_generate_active, adv_ready,
        output pll54_lockloss, pll_hdmi_lockloss, resync_rise
    );

    modport sink (
        input pll_hdmi_ready, resync_active, force_generate_active, adv_ready,
        input pll54_lockloss, pll_hdmi_lockloss, resync_rise
    );

endinterface

// ==== src/supervisor_pkg.sv ====
`include "supervisor_defs.svh"

package supervisor_pkg;

    // event counters wrap at full width
    typedef logic [`SUP_COUNT_WIDTH-1:0] event_count_t;

    // what the status led shows
    typedef enum logic [1:0] {
        led_board_status  = 2'd0,
        led_opt_reset     = 2'd1,
        led_dc_reset      = 2'd2,
        led_opt_reset_alt = 2'd3
    } reset_conf_e;

endpackage

// ==== tb.f ====
+incdir+src
src/supervisor_pkg.sv
src/supervisor_events_if.sv
src/input_sync_stage.sv
src/event_count_stage.sv
src/reset_hold.sv
src/led_glow.sv
src/status_led_select.sv
src/board_supervisor_top.sv
verification/tb_board_supervisor.sv

// ==== verification/tb_board_supervisor.sv ====
module tb_board_supervisor;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int hold_time   = 20;
    localparam int clk_half    = 20;
    localparam int event_steps = 12;
    // cycle budgets of tests 1 to 6 plus reset
    localparam int test_cycles = 4 + 5 * hold_time + 66 + event_steps * 8 + 16 + 120 + 180;
    localparam int watchdog_ns = test_cycles * 2 * clk_half * 6 / 5;

    logic        control_clock = 1'b0;
    logic        reset_dc;
    logic        reset_opt;
    logic [1:0]  reset_conf;
    logic        pll54_locked;
    logic        pll_hdmi_locked;
    logic        resync;
    logic        force_generate;
    logic        adv7513_ready;
    logic        dc_nreset;
    logic        opt_nreset;
    logic        status_led;
    logic [31:0] pll54_lockloss_count;
    logic [31:0] pll_hdmi_lockloss_count;
    logic [31:0] resync_count;

    // expected state and check enables
    int          dc_idle_cycles  = hold_time + 1;
    int          opt_idle_cycles = hold_time + 1;
    logic [31:0] tally_pll54     = '0;
    logic [31:0] tally_pll_hdmi  = '0;
    logic [31:0] tally_resync    = '0;
    logic [31:0] rng_state       = 32'd65;
    bit          checks_on       = 1'b0;
    bit          count_strobe    = 1'b0;
    bit          expect_led_high = 1'b0;
    bit          expect_led_low  = 1'b0;
    bit          dc_mode_check   = 1'b0;
    bit          opt_mode_check  = 1'b0;
    bit          window_clear    = 1'b0;
    bit          window_check    = 1'b0;
    bit          long_high_check = 1'b0;
    bit          seen_led_high   = 1'b0;
    bit          seen_led_low    = 1'b0;
    bit          seen_long_high  = 1'b0;
    int          high_run        = 0;
    int          error_count     = 0;
    int          errors_before   = 0;
    int          tests_run       = 0;
    int          tests_failed    = 0;

    board_supervisor_top #(
        .hold_time(hold_time),
        .slow_bit(5),
        .fast_bit(3),
        .blink_bit(4)
    ) board_supervisor_top_inst (.*);

    always #(clk_half) control_clock = ~control_clock;

    ////////////////////////////////////////////////////////////////////////////
    // reference model and led monitor
    ////////////////////////////////////////////////////////////////////////////
    // saturating count of cycles since each reset request was last high
    always @(posedge control_clock) begin
        if (reset_dc) begin
            dc_idle_cycles <= 0;
        end else if (dc_idle_cycles <= hold_time) begin
            dc_idle_cycles <= dc_idle_cycles + 1;
        end
        if (reset_opt) begin
            opt_idle_cycles <= 0;
        end else if (opt_idle_cycles <= hold_time) begin
            opt_idle_cycles <= opt_idle_cycles + 1;
        end
    end

    always @(posedge control_clock) begin
        if (window_clear) begin
            seen_led_high  <= 1'b0;
            seen_led_low   <= 1'b0;
            seen_long_high <= 1'b0;
            high_run       <= 0;
        end else if (status_led === 1'b1) begin
            seen_led_high <= 1'b1;
            high_run      <= high_run + 1;
            if (high_run >= 15) begin
                seen_long_high <= 1'b1;
            end
        end else begin
            high_run <= 0;
            if (status_led === 1'b0) begin
                seen_led_low <= 1'b1;
            end
        end
    end

    dc_hold_check: assert property (@(posedge control_clock)
        checks_on |-> dc_nreset == (dc_idle_cycles > hold_time))
        else report_error("dc_nreset does not follow the hold time");
    opt_hold_check: assert property (@(posedge control_clock)
        checks_on |-> opt_nreset == (opt_idle_cycles > hold_time))
        else report_error("opt_nreset does not follow the hold time");
    pll54_count_check: assert property (@(posedge control_clock)
        count_strobe |-> pll54_lockloss_count == tally_pll54)
        else report_error("pll54_lockloss_count differs from the tally");
    pll_hdmi_count_check: assert property (@(posedge control_clock)
        count_strobe |-> pll_hdmi_lockloss_count == tally_pll_hdmi)
        else report_error("pll_hdmi_lockloss_count differs from the tally");
    resync_count_check: assert property (@(posedge control_clock)
        count_strobe |-> resync_count == tally_resync)
        else report_error("resync_count differs from the tally");
    led_dark_check: assert property (@(posedge control_clock)
        expect_led_high |-> status_led == 1'b1)
        else report_error("status_led lit while the hdmi pll is unlocked");
    led_lit_check: assert property (@(posedge control_clock)
        expect_led_low |-> status_led == 1'b0)
        else report_error("status_led dark with the transmitter ready");
    led_window_check: assert property (@(posedge control_clock)
        window_check |-> seen_led_high && seen_led_low)
        else report_error("status_led did not take both values in the window");
    led_blink_check: assert property (@(posedge control_clock)
        long_high_check |-> seen_long_high)
        else report_error("status_led never stayed high for 16 cycles");
    led_dc_mode_check: assert property (@(posedge control_clock)
        dc_mode_check && !$past(reset_dc) |-> status_led == $past(dc_nreset))
        else report_error("status_led does not follow dc_nreset");
    led_opt_mode_check: assert property (@(posedge control_clock)
        opt_mode_check |-> status_led == $past(opt_nreset))
        else report_error("status_led does not follow opt_nreset");

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic report_error(input string msg);
        error_count++;
        $display("** Error at %0d ns: %s", $time, msg);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge control_clock);
        #2;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic strobe_counts();
        count_strobe = 1'b1;
        wait_cycles(1);
        count_strobe = 1'b0;
    endtask

    task automatic pulse_reset_opt();
        reset_opt = 1'b1;
        wait_cycles(3);
        reset_opt = 1'b0;
        wait_cycles(hold_time + 8);
    endtask

    task automatic watch_led_window(input int cycles, input bit need_long_high);
        window_clear = 1'b1;
        wait_cycles(1);
        window_clear = 1'b0;
        wait_cycles(cycles);
        window_check    = 1'b1;
        long_high_check = need_long_high;
        wait_cycles(1);
        window_check    = 1'b0;
        long_high_check = 1'b0;
    endtask

    task automatic run_event_counting();
        int sel;
        int step_cycles;
        for (int i = 0; i < event_steps; i++) begin
            rng_state   = xorshift32(rng_state);
            sel         = (i < 3) ? i : int'(rng_state % 3);
            step_cycles = 4 + int'((rng_state >> 8) % 4);
            case (sel)
                0: begin
                    tally_pll54  = pll54_locked ? tally_pll54 + 1 : tally_pll54;
                    pll54_locked = ~pll54_locked;
                end
                1: begin
                    tally_pll_hdmi  = pll_hdmi_locked ? tally_pll_hdmi + 1 : tally_pll_hdmi;
                    pll_hdmi_locked = ~pll_hdmi_locked;
                end
                default: begin
                    tally_resync = resync ? tally_resync : tally_resync + 1;
                    resync       = ~resync;
                end
            endcase
            wait_cycles(step_cycles);
        end
        pll54_locked    = 1'b1;
        pll_hdmi_locked = 1'b1;
        resync          = 1'b0;
        wait_cycles(8);
        strobe_counts();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        reset_dc        = 1'b1;
        reset_opt       = 1'b0;
        reset_conf      = 2'd0;
        pll54_locked    = 1'b1;
        pll_hdmi_locked = 1'b1;
        resync          = 1'b0;
        force_generate  = 1'b0;
        adv7513_ready   = 1'b0;
        wait_cycles(2);
        reset_dc  = 1'b0;
        checks_on = 1'b1;

        wait_cycles(hold_time + 8);
        strobe_counts();
        finish_test("console reset");

        pulse_reset_opt();
        finish_test("optional reset");

        run_event_counting();
        finish_test("event counting");

        pll_hdmi_locked = 1'b0;
        wait_cycles(4);
        expect_led_high = 1'b1;
        wait_cycles(16);
        expect_led_high = 1'b0;
        pll_hdmi_locked = 1'b1;
        adv7513_ready   = 1'b1;
        wait_cycles(5);
        expect_led_low = 1'b1;
        wait_cycles(16);
        expect_led_low = 1'b0;
        adv7513_ready  = 1'b0;
        wait_cycles(4);
        watch_led_window(64, 1'b0);
        finish_test("led priority");

        // console reset also clears the counters
        reset_conf = 2'd2;
        wait_cycles(1);
        dc_mode_check = 1'b1;
        reset_dc      = 1'b1;
        wait_cycles(2);
        reset_dc       = 1'b0;
        tally_pll54    = '0;
        tally_pll_hdmi = '0;
        tally_resync   = '0;
        wait_cycles(hold_time + 8);
        strobe_counts();
        dc_mode_check = 1'b0;
        reset_conf    = 2'd1;
        wait_cycles(1);
        opt_mode_check = 1'b1;
        pulse_reset_opt();
        reset_conf = 2'd3;
        wait_cycles(1);
        pulse_reset_opt();
        opt_mode_check = 1'b0;
        finish_test("led reset modes");

        reset_conf = 2'd0;
        resync     = 1'b1;
        wait_cycles(4);
        watch_led_window(32, 1'b0);
        resync         = 1'b0;
        force_generate = 1'b1;
        wait_cycles(4);
        watch_led_window(128, 1'b1);
        finish_test("resync and forced generation");

        $display("tests run: %0d, tests failed: %0d, check errors: %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("simulation timed out after %0d ns before the tests finished", watchdog_ns);
        $display("Test failed");
        $finish;
    end

endmodule
